/* design/query_register.sv */
// query register
//   holds one base per systolic cell
//   builds the active mask from the query length
`timescale 1ns/1ns

module query_register (
    input  logic                                              PicoClk,
    input  logic                                              rstSmWa,
    input  logic                                              query_load,
    input  smwa_pkg::stream_word_t                            query_word,
    input  smwa_pkg::query_len_t                              query_len,
    output smwa_pkg::base_t [smwa_pkg::MAX_QUERY_LEN-1:0]     query_bases,
    output logic [smwa_pkg::MAX_QUERY_LEN-1:0]                cell_active
);

    // base k of the word lands in cell k
    always_ff @(posedge PicoClk) begin
        if (query_load) begin
            query_bases <= query_word;
        end
    end

    // cells 0 .. len-1 take part, the rest pass through
    always_ff @(posedge PicoClk) begin
        if (rstSmWa) begin
            cell_active <= '0;
        end else if (query_load) begin
            for (int i = 0; i < smwa_pkg::MAX_QUERY_LEN; i++) begin
                cell_active[i] <= (i < query_len);
            end
        end
    end

endmodule

/* design/smwa_ctrl.sv */
// control fsm
//   consumes query and target headers
//   loads the query, starts the target shifter
//   holds off a new target until the score fifo has room
`timescale 1ns/1ns

module smwa_ctrl (
    input  logic                   PicoClk,
    input  logic                   rstSmWa,
    input  smwa_pkg::stream_word_t q_word,
    input  logic                   q_valid,
    output logic                   q_ready,
    input  smwa_pkg::stream_word_t t_word,
    input  logic                   t_valid,
    output logic                   t_ready,
    input  smwa_pkg::fifo_cnt_t    score_count,
    input  logic                   shifter_busy,
    input  logic                   shifter_word_ready,
    input  logic                   align_done,
    output logic                   query_load,
    output smwa_pkg::query_len_t   query_len,
    output logic                   target_start,
    output smwa_pkg::target_len_t  target_len
);

    typedef enum logic [2:0] {
        S_Q_HDR,
        S_Q_DATA,
        S_ROOM,
        S_T_HDR,
        S_STREAM,
        S_DONE
    } state_t;

    state_t state;

    ////////////////////
    // stream readies
    ////////////////////
    assign q_ready    = (state == S_Q_HDR) || (state == S_Q_DATA);
    // shifter owns the target fifo while streaming
    assign t_ready    = (state == S_T_HDR) || ((state == S_STREAM) && shifter_word_ready);
    // query word goes straight to the register on its transfer
    assign query_load = (state == S_Q_DATA) && q_valid;

    always_ff @(posedge PicoClk) begin
        if (rstSmWa) begin
            state        <= S_Q_HDR;
            target_start <= 1'b0;
            query_len    <= '0;
            target_len   <= '0;
        end else begin
            target_start <= 1'b0;
            case (state)
                S_Q_HDR: begin
                    if (q_valid) begin
                        query_len <= q_word[smwa_pkg::QUERY_LEN_W-1:0];
                        state     <= S_Q_DATA;
                    end
                end
                S_Q_DATA: begin
                    if (q_valid) begin
                        state <= S_ROOM;
                    end
                end
                // keep one slot free for the score in flight
                S_ROOM: begin
                    if (score_count < smwa_pkg::FIFO_DEPTH - 1) begin
                        state <= S_T_HDR;
                    end
                end
                S_T_HDR: begin
                    if (t_valid) begin
                        target_len   <= t_word[smwa_pkg::TARGET_LEN_W-1:0];
                        target_start <= 1'b1;
                        state        <= S_STREAM;
                    end
                end
                // shifter goes busy the cycle after the start pulse
                S_STREAM: begin
                    if (!target_start && !shifter_busy) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (align_done) begin
                        state <= S_Q_HDR;
                    end
                end
                default: begin
                    state <= S_Q_HDR;
                end
            endcase
        end
    end

    // only one alignment in the array at a time
    a_one_in_flight: assert property (@(posedge PicoClk) disable iff (rstSmWa)
        target_start |=> (!target_start throughout align_done[->1]));

endmodule

/* design/smwa_pkg.sv */
// shared definitions for the smith-waterman unit
//   base, stream and score widths
//   query and target length limits
//   stream word, score and counter types
//   signed max helper for the scoring datapath
package smwa_pkg;

    // base and stream geometry
    localparam int BASE_W         = 2;
    localparam int STREAM_W       = 32;
    localparam int BASES_PER_WORD = STREAM_W / BASE_W;

    // one systolic cell per query base
    localparam int MAX_QUERY_LEN  = 16;
    localparam int QUERY_LEN_W    = 5;
    localparam int TARGET_LEN_W   = 8;

    // signed score, wide enough for 16 matches of 7 plus headroom
    localparam int SCORE_W        = 10;

    // stream fifo depth and derived counter widths
    localparam int FIFO_DEPTH     = 4;
    localparam int FIFO_CNT_W     = $clog2(FIFO_DEPTH + 1);
    localparam int BASE_CNT_W     = $clog2(BASES_PER_WORD + 1);

    typedef logic [BASE_W-1:0]         base_t;
    // header: bits 4:0 query len or bits 7:0 target len
    // data: base k in bits 2k+1:2k, lsb base first
    typedef logic [STREAM_W-1:0]       stream_word_t;
    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [QUERY_LEN_W-1:0]    query_len_t;
    typedef logic [TARGET_LEN_W-1:0]   target_len_t;
    typedef logic [FIFO_CNT_W-1:0]     fifo_cnt_t;
    typedef logic [BASE_CNT_W-1:0]     base_cnt_t;

    // larger of two signed scores
    function automatic score_t max_score(score_t a, score_t b);
        return (a > b) ? a : b;
    endfunction

endpackage

/* design/smwa_top.sv */
// smith-waterman top level
//   query, target and score fifos
//   control fsm, query register, target shifter, systolic array
`timescale 1ns/1ns

module smwa_top (
    input  logic                   PicoClk,
    input  logic                   rstSmWa,
    input  logic                   query_valid,
    output logic                   query_ready,
    input  smwa_pkg::stream_word_t query_data,
    input  logic                   target_valid,
    output logic                   target_ready,
    input  smwa_pkg::stream_word_t target_data,
    output logic                   score_valid,
    input  logic                   score_ready,
    output smwa_pkg::score_t       score_data,
    input  smwa_pkg::score_t       match,
    input  smwa_pkg::score_t       mismatch,
    input  smwa_pkg::score_t       gap_open
);

    // fifo outputs into control
    smwa_pkg::stream_word_t                        q_word;
    logic                                          q_valid;
    logic                                          q_ready;
    smwa_pkg::stream_word_t                        t_word;
    logic                                          t_valid;
    logic                                          t_ready;
    smwa_pkg::fifo_cnt_t                           score_count;
    // control to datapath
    logic                                          query_load;
    smwa_pkg::query_len_t                          query_len;
    logic                                          target_start;
    smwa_pkg::target_len_t                         target_len;
    logic                                          shifter_busy;
    logic                                          shifter_word_ready;
    // datapath
    smwa_pkg::base_t [smwa_pkg::MAX_QUERY_LEN-1:0] query_bases;
    logic [smwa_pkg::MAX_QUERY_LEN-1:0]            cell_active;
    smwa_pkg::base_t                               base;
    logic                                          base_valid;
    logic                                          base_first;
    logic                                          base_last;
    smwa_pkg::score_t                              align_score;
    logic                                          align_done;

    ////////////////////
    // stream fifos
    ////////////////////
    stream_fifo #(.payload_t(smwa_pkg::stream_word_t)) u_query_fifo (
        .PicoClk (PicoClk), .rstSmWa (rstSmWa),
        .in_data (query_data), .in_valid (query_valid), .in_ready (query_ready),
        .out_data (q_word), .out_valid (q_valid), .out_ready (q_ready),
        .count ()
    );

    stream_fifo #(.payload_t(smwa_pkg::stream_word_t)) u_target_fifo (
        .PicoClk (PicoClk), .rstSmWa (rstSmWa),
        .in_data (target_data), .in_valid (target_valid), .in_ready (target_ready),
        .out_data (t_word), .out_valid (t_valid), .out_ready (t_ready),
        .count ()
    );

    // room is checked by control before each target, so in_ready stays open
    stream_fifo #(.payload_t(smwa_pkg::score_t)) u_score_fifo (
        .PicoClk (PicoClk), .rstSmWa (rstSmWa),
        .in_data (align_score), .in_valid (align_done), .in_ready (),
        .out_data (score_data), .out_valid (score_valid), .out_ready (score_ready),
        .count (score_count)
    );

    ////////////////////
    // control and datapath
    ////////////////////
    smwa_ctrl u_ctrl (
        .PicoClk (PicoClk), .rstSmWa (rstSmWa),
        .q_word (q_word), .q_valid (q_valid), .q_ready (q_ready),
        .t_word (t_word), .t_valid (t_valid), .t_ready (t_ready),
        .score_count (score_count),
        .shifter_busy (shifter_busy), .shifter_word_ready (shifter_word_ready),
        .align_done (align_done),
        .query_load (query_load), .query_len (query_len),
        .target_start (target_start), .target_len (target_len)
    );

    query_register u_query_reg (
        .PicoClk (PicoClk), .rstSmWa (rstSmWa),
        .query_load (query_load), .query_word (q_word), .query_len (query_len),
        .query_bases (query_bases), .cell_active (cell_active)
    );

    target_shifter u_target_shifter (
        .PicoClk (PicoClk), .rstSmWa (rstSmWa),
        .target_start (target_start), .target_len (target_len),
        .word (t_word), .word_valid (t_valid), .word_ready (shifter_word_ready),
        .base (base), .base_valid (base_valid), .base_first (base_first),
        .base_last (base_last), .busy (shifter_busy)
    );

    systolic_array u_array (
        .PicoClk (PicoClk), .rstSmWa (rstSmWa),
        .query_bases (query_bases), .cell_active (cell_active),
        .match (match), .mismatch (mismatch), .gap_open (gap_open),
        .base (base), .base_valid (base_valid), .base_first (base_first),
        .base_last (base_last),
        .score (align_score), .score_valid (align_done)
    );

endmodule

/* design/stream_fifo.sv */
// synchronous valid/ready fifo
//   circular buffer, payload type set by parameter
//   occupancy count for back-pressure decisions
`timescale 1ns/1ns

module stream_fifo #(
    parameter type payload_t = smwa_pkg::stream_word_t
) (
    input  logic                PicoClk,
    input  logic                rstSmWa,
    input  payload_t            in_data,
    input  logic                in_valid,
    output logic                in_ready,
    output payload_t            out_data,
    output logic                out_valid,
    input  logic                out_ready,
    output smwa_pkg::fifo_cnt_t count
);

    payload_t                                mem [smwa_pkg::FIFO_DEPTH];
    logic [$clog2(smwa_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(smwa_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic                                    wr_en;
    logic                                    rd_en;

    // full/empty straight from the count
    assign in_ready  = (count != smwa_pkg::FIFO_DEPTH);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge PicoClk) begin
        if (rstSmWa) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == smwa_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == smwa_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + smwa_pkg::fifo_cnt_t'(wr_en) - smwa_pkg::fifo_cnt_t'(rd_en);
        end
    end

    // storage only, no reset
    always_ff @(posedge PicoClk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // a word offered while full must stay put until there is room
    // the score path never holds its pulse, so this catches a lost score
    a_no_write_when_full: assert property (@(posedge PicoClk) disable iff (rstSmWa)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_data)));

endmodule

/* design/sw_cell.sv */
// one systolic cell
//   computes one row of the local-alignment matrix
//   linear gap scoring, floor at zero
//   running max of its row
`timescale 1ns/1ns

module sw_cell (
    input  logic             PicoClk,
    input  logic             rstSmWa,
    input  smwa_pkg::base_t  query_base,
    input  logic             active,
    input  smwa_pkg::score_t match,
    input  smwa_pkg::score_t mismatch,
    input  smwa_pkg::score_t gap_open,
    input  smwa_pkg::base_t  in_base,
    input  logic             in_valid,
    input  logic             in_first,
    input  logic             in_last,
    input  smwa_pkg::score_t in_h,
    input  smwa_pkg::score_t in_h_diag,
    output smwa_pkg::base_t  out_base,
    output logic             out_valid,
    output logic             out_first,
    output logic             out_last,
    output smwa_pkg::score_t out_h,
    output smwa_pkg::score_t out_h_diag,
    output smwa_pkg::score_t cell_max
);

    smwa_pkg::score_t h_reg;
    smwa_pkg::score_t max_reg;
    smwa_pkg::score_t h_prev;
    smwa_pkg::score_t max_prev;
    smwa_pkg::score_t diag_sc;
    smwa_pkg::score_t up_sc;
    smwa_pkg::score_t left_sc;
    smwa_pkg::score_t h_new;

    //////////////////////
    // score for this column
    //////////////////////
    always_comb begin
        // first base starts a fresh matrix
        h_prev   = in_first ? '0 : h_reg;
        max_prev = in_first ? '0 : max_reg;
        diag_sc  = in_h_diag + ((in_base == query_base) ? match : mismatch);
        up_sc    = in_h + gap_open;
        left_sc  = h_prev + gap_open;
        h_new    = smwa_pkg::max_score(smwa_pkg::max_score(diag_sc, up_sc),
                                       smwa_pkg::max_score(left_sc, '0));
    end

    always_ff @(posedge PicoClk) begin
        if (rstSmWa) begin
            out_valid <= 1'b0;
            h_reg     <= '0;
            max_reg   <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid && active) begin
                h_reg   <= h_new;
                max_reg <= smwa_pkg::max_score(max_prev, h_new);
            end
        end
    end

    // to the next cell, qualified by out_valid
    // diag for the next row is this row's value one column back
    always_ff @(posedge PicoClk) begin
        out_base   <= in_base;
        out_first  <= in_first;
        out_last   <= in_last;
        out_h      <= active ? h_new : in_h;
        out_h_diag <= active ? h_prev : in_h_diag;
    end

    // unused rows report nothing
    assign cell_max = active ? max_reg : '0;

endmodule

/* design/systolic_array.sv */
// systolic array
//   chain of MAX_QUERY_LEN cells
//   last mark drains through the chain
//   max over all cell maxima into one score pulse
`timescale 1ns/1ns

module systolic_array (
    input  logic                                          PicoClk,
    input  logic                                          rstSmWa,
    input  smwa_pkg::base_t [smwa_pkg::MAX_QUERY_LEN-1:0] query_bases,
    input  logic [smwa_pkg::MAX_QUERY_LEN-1:0]            cell_active,
    input  smwa_pkg::score_t                              match,
    input  smwa_pkg::score_t                              mismatch,
    input  smwa_pkg::score_t                              gap_open,
    input  smwa_pkg::base_t                               base,
    input  logic                                          base_valid,
    input  logic                                          base_first,
    input  logic                                          base_last,
    output smwa_pkg::score_t                              score,
    output logic                                          score_valid
);

    // slot i feeds cell i, slot MAX_QUERY_LEN is the chain output
    smwa_pkg::base_t  c_base  [smwa_pkg::MAX_QUERY_LEN+1];
    logic             c_valid [smwa_pkg::MAX_QUERY_LEN+1];
    logic             c_first [smwa_pkg::MAX_QUERY_LEN+1];
    logic             c_last  [smwa_pkg::MAX_QUERY_LEN+1];
    smwa_pkg::score_t c_h     [smwa_pkg::MAX_QUERY_LEN+1];
    smwa_pkg::score_t c_diag  [smwa_pkg::MAX_QUERY_LEN+1];
    smwa_pkg::score_t c_max   [smwa_pkg::MAX_QUERY_LEN];
    smwa_pkg::score_t best;

    // row above cell 0 is all zero
    assign c_base[0]  = base;
    assign c_valid[0] = base_valid;
    assign c_first[0] = base_first;
    assign c_last[0]  = base_last;
    assign c_h[0]     = '0;
    assign c_diag[0]  = '0;

    for (genvar i = 0; i < smwa_pkg::MAX_QUERY_LEN; i++) begin : g_cell
        sw_cell u_cell (
            .PicoClk    (PicoClk),
            .rstSmWa    (rstSmWa),
            .query_base (query_bases[i]),
            .active     (cell_active[i]),
            .match      (match),
            .mismatch   (mismatch),
            .gap_open   (gap_open),
            .in_base    (c_base[i]),
            .in_valid   (c_valid[i]),
            .in_first   (c_first[i]),
            .in_last    (c_last[i]),
            .in_h       (c_h[i]),
            .in_h_diag  (c_diag[i]),
            .out_base   (c_base[i+1]),
            .out_valid  (c_valid[i+1]),
            .out_first  (c_first[i+1]),
            .out_last   (c_last[i+1]),
            .out_h      (c_h[i+1]),
            .out_h_diag (c_diag[i+1]),
            .cell_max   (c_max[i])
        );
    end

    ////////////////////
    // max reduction
    ////////////////////
    always_comb begin
        best = '0;
        for (int i = 0; i < smwa_pkg::MAX_QUERY_LEN; i++) begin
            best = smwa_pkg::max_score(best, c_max[i]);
        end
    end

    // last mark leaving the final cell means every row is done
    always_ff @(posedge PicoClk) begin
        if (rstSmWa) begin
            score_valid <= 1'b0;
        end else begin
            score_valid <= c_valid[smwa_pkg::MAX_QUERY_LEN] && c_last[smwa_pkg::MAX_QUERY_LEN];
        end
    end

    always_ff @(posedge PicoClk) begin
        if (c_valid[smwa_pkg::MAX_QUERY_LEN] && c_last[smwa_pkg::MAX_QUERY_LEN]) begin
            score <= best;
        end
    end

    // one score per target, never a held level
    a_score_pulse: assert property (@(posedge PicoClk) disable iff (rstSmWa)
        score_valid |=> !score_valid);

endmodule

/* design/target_shifter.sv */
// target shifter
//   pulls target data words from the fifo on its own
//   shifts out one base per cycle, lsb base first
//   marks first and last base of the target
`timescale 1ns/1ns

module target_shifter (
    input  logic                   PicoClk,
    input  logic                   rstSmWa,
    input  logic                   target_start,
    input  smwa_pkg::target_len_t  target_len,
    input  smwa_pkg::stream_word_t word,
    input  logic                   word_valid,
    output logic                   word_ready,
    output smwa_pkg::base_t        base,
    output logic                   base_valid,
    output logic                   base_first,
    output logic                   base_last,
    output logic                   busy
);

    smwa_pkg::target_len_t  remaining;
    smwa_pkg::base_cnt_t    word_left;
    smwa_pkg::stream_word_t shreg;
    logic                   first_pending;
    smwa_pkg::target_len_t  rem_next;
    logic                   load;

    // remaining counts bases not yet sent
    assign busy       = (remaining != '0);
    assign base_valid = (word_left != '0);
    assign base       = shreg[smwa_pkg::BASE_W-1:0];
    assign base_first = first_pending;
    assign base_last  = base_valid && (remaining == smwa_pkg::target_len_t'(1));

    // fetch ahead on the last base of a word, so no bubble when the fifo keeps up
    assign word_ready = (word_left <= smwa_pkg::base_cnt_t'(1)) && (remaining > word_left);
    assign load       = word_valid && word_ready;
    assign rem_next   = remaining - smwa_pkg::target_len_t'(base_valid);

    always_ff @(posedge PicoClk) begin
        if (rstSmWa) begin
            remaining     <= '0;
            word_left     <= '0;
            first_pending <= 1'b0;
        end else if (target_start) begin
            remaining     <= target_len;
            word_left     <= '0;
            first_pending <= 1'b1;
        end else begin
            remaining <= rem_next;
            if (base_valid) begin
                first_pending <= 1'b0;
            end
            // last word may be partly used
            if (load) begin
                word_left <= (rem_next > smwa_pkg::BASES_PER_WORD) ?
                             smwa_pkg::base_cnt_t'(smwa_pkg::BASES_PER_WORD) :
                             smwa_pkg::base_cnt_t'(rem_next);
            end else if (base_valid) begin
                word_left <= word_left - 1'b1;
            end
        end
    end

    always_ff @(posedge PicoClk) begin
        if (load) begin
            shreg <= word;
        end else if (base_valid) begin
            shreg <= shreg >> smwa_pkg::BASE_W;
        end
    end

    // bases left in the word imply bases left in the target
    a_valid_only_busy: assert property (@(posedge PicoClk) disable iff (rstSmWa)
        base_valid |-> busy);

endmodule

/* smwa.f */
+incdir+tb
design/smwa_pkg.sv
design/stream_fifo.sv
design/query_register.sv
design/target_shifter.sv
design/sw_cell.sv
design/systolic_array.sv
design/smwa_ctrl.sv
design/smwa_top.sv
tb/smwa_tb.sv

/* tb/smwa_model.svh */
// reference model for the smith-waterman unit
//   best local-alignment score with linear gaps and a floor at zero
//   query bases packed two bits each, lsb base first
//   target bases packed the same way, up to 256 bases
`ifndef SMWA_MODEL_SVH
`define SMWA_MODEL_SVH

// larger of two ints
function automatic int larger(input int a, input int b);
    return (a > b) ? a : b;
endfunction

// full matrix walk, one target base per column
function automatic int align_score(
    input int           qlen,
    input logic [31:0]  qbits,
    input int           tlen,
    input logic [511:0] tbits,
    input int           m,
    input int           mm,
    input int           g
);
    int h_prev [16];
    int h_cur  [16];
    int best;
    int diag;
    int up;
    int sub;
    int v;
    best = 0;
    for (int i = 0; i < 16; i++) begin
        h_prev[i] = 0;
        h_cur[i]  = 0;
    end
    for (int j = 0; j < tlen; j++) begin
        for (int i = 0; i < qlen; i++) begin
            // row above the first query base is all zero
            diag     = (i == 0) ? 0 : h_prev[i-1];
            up       = (i == 0) ? 0 : h_cur[i-1];
            sub      = (qbits[2*i +: 2] == tbits[2*j +: 2]) ? m : mm;
            v        = larger(larger(0, diag + sub), larger(up + g, h_prev[i] + g));
            h_cur[i] = v;
            best     = larger(best, v);
        end
        // this column becomes the previous one
        for (int i = 0; i < qlen; i++) begin
            h_prev[i] = h_cur[i];
        end
    end
    return best;
endfunction

`endif

/* tb/smwa_tb.sv */
// testbench for the smith-waterman unit
//   clock, reset and valid/ready stream drivers
//   directed edge lengths, substring and mismatch cases
//   random alignments checked against the reference model
//   score consumer with random back-pressure and hold checks
`timescale 1ns/1ns

module smwa_tb;

    localparam int SEED          = 32'h3995;
    localparam int NUM_RANDOM    = 60;
    localparam int WORD_TIMEOUT  = 20000;
    localparam int DRAIN_TIMEOUT = 40000;

    logic                   PicoClk;
    logic                   rstSmWa;
    logic                   query_valid;
    logic                   query_ready;
    smwa_pkg::stream_word_t query_data;
    logic                   target_valid;
    logic                   target_ready;
    smwa_pkg::stream_word_t target_data;
    logic                   score_valid;
    logic                   score_ready;
    smwa_pkg::score_t       score_data;
    smwa_pkg::score_t       match;
    smwa_pkg::score_t       mismatch;
    smwa_pkg::score_t       gap_open;

    // driver and consumer each draw from their own seed
    integer seed;
    integer ready_seed;
    int     cur_m;
    int     cur_mm;
    int     cur_g;
    // expected scores in send order
    int     exp_q [$];

    `include "smwa_model.svh"

    smwa_top dut (
        .PicoClk (PicoClk), .rstSmWa (rstSmWa),
        .query_valid (query_valid), .query_ready (query_ready), .query_data (query_data),
        .target_valid (target_valid), .target_ready (target_ready),
        .target_data (target_data),
        .score_valid (score_valid), .score_ready (score_ready), .score_data (score_data),
        .match (match), .mismatch (mismatch), .gap_open (gap_open)
    );

    always #4 PicoClk = ~PicoClk;

    ////////////////////
    // error handling
    ////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    ////////////////////
    // stream drivers
    ////////////////////
    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_word(input bit to_target, input smwa_pkg::stream_word_t w);
        int t;
        if (to_target) begin
            target_data  = w;
            target_valid = 1'b1;
        end else begin
            query_data  = w;
            query_valid = 1'b1;
        end
        t = 0;
        // ready only moves on a rising edge, so it is stable here
        while (!(to_target ? target_ready : query_ready)) begin
            @(negedge PicoClk);
            t++;
            if (t > WORD_TIMEOUT) begin
                stop_on_error(to_target ? "timeout: target stream never became ready" :
                                          "timeout: query stream never became ready");
            end
        end
        @(negedge PicoClk);
        query_valid  = 1'b0;
        target_valid = 1'b0;
    endtask

    // headers first, then the packed bases
    task automatic send_alignment(input int qlen, input logic [31:0] qbits,
                                  input int tlen, input logic [511:0] tbits,
                                  output int expv);
        int nwords;
        expv = align_score(qlen, qbits, tlen, tbits, cur_m, cur_mm, cur_g);
        exp_q.push_back(expv);
        nwords = (tlen + 15) / 16;
        send_word(1'b0, 32'(qlen));
        send_word(1'b0, qbits);
        send_word(1'b1, 32'(tlen));
        for (int k = 0; k < nwords; k++) begin
            send_word(1'b1, tbits[32*k +: 32]);
        end
    endtask

    // unused bases in the last word are random as well
    task automatic run_random(input int qlen, input int tlen);
        logic [31:0]  qbits;
        logic [511:0] tbits;
        int           expv;
        qbits = $random(seed);
        for (int k = 0; k < 16; k++) begin
            tbits[32*k +: 32] = $random(seed);
        end
        send_alignment(qlen, qbits, tlen, tbits, expv);
    endtask

    // new scoring values while nothing is in flight
    task automatic set_scores();
        cur_m    = 1 + ($unsigned($random(seed)) % 7);
        cur_mm   = -(1 + ($unsigned($random(seed)) % 7));
        cur_g    = -(1 + ($unsigned($random(seed)) % 7));
        match    = smwa_pkg::score_t'(cur_m);
        mismatch = smwa_pkg::score_t'(cur_mm);
        gap_open = smwa_pkg::score_t'(cur_g);
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            @(negedge PicoClk);
            t++;
            if (t > DRAIN_TIMEOUT) begin
                stop_on_error("timeout: outstanding scores never came out of the DUT");
            end
        end
    endtask

    task automatic run_alone(input int qlen, input int tlen);
        wait_drained();
        set_scores();
        run_random(qlen, tlen);
    endtask

    ////////////////////
    // score consumer
    ////////////////////
    task automatic consume_scores();
        int               hold_left;
        logic             held;
        smwa_pkg::score_t held_data;
        int               expv;
        hold_left = 0;
        held      = 1'b0;
        held_data = '0;
        forever begin
            @(negedge PicoClk);
            // a stalled score must still be there with the same data
            if (held) begin
                check_eq("score_valid", score_valid, 1);
                check_eq("score_data", score_data, held_data);
            end
            // ready runs in random high and low periods
            // long low periods let the score fifo fill and hold off new targets
            if (hold_left == 0) begin
                score_ready = ($random(ready_seed) & 3) != 0;
                hold_left   = 1 + ($unsigned($random(ready_seed)) %
                                   (score_ready ? 24 : 1000));
            end
            hold_left--;
            held      = score_valid && !score_ready;
            held_data = score_data;
            if (score_valid && score_ready) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("score delivered with no alignment outstanding");
                end
                expv = exp_q.pop_front();
                check_eq("score_data", score_data, expv);
            end
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        int           group;
        int           left;
        int           expv;
        logic [31:0]  qbits;
        logic [511:0] tbits;
        PicoClk      = 1'b0;
        rstSmWa      = 1'b1;
        query_valid  = 1'b0;
        query_data   = '0;
        target_valid = 1'b0;
        target_data  = '0;
        score_ready  = 1'b0;
        match        = '0;
        mismatch     = '0;
        gap_open     = '0;
        seed         = SEED;
        ready_seed   = ~SEED;
        repeat (8) @(negedge PicoClk);
        rstSmWa = 1'b0;

        // idle after reset with empty fifos
        repeat (4) begin
            @(negedge PicoClk);
            check_eq("score_valid", score_valid, 0);
            check_eq("query_ready", query_ready, 1);
            check_eq("target_ready", target_ready, 1);
        end
        fork
            consume_scores();
        join_none

        // edge lengths with single and multi word targets and a partial last word
        run_alone(1, 1);
        run_alone(16, 16);
        run_alone(16, 17);
        run_alone(1, 255);
        run_alone(16, 255);
        run_alone(5, 33);

        // query copied from target bases 12..19
        wait_drained();
        set_scores();
        qbits = $random(seed);
        for (int k = 0; k < 16; k++) begin
            tbits[32*k +: 32] = $random(seed);
        end
        for (int i = 0; i < 8; i++) begin
            qbits[2*i +: 2] = tbits[2*(12+i) +: 2];
        end
        send_alignment(8, qbits, 40, tbits, expv);
        check_eq("substring_bound", expv >= cur_m * 8, 1);

        // query all base 0 against a target without base 0
        wait_drained();
        set_scores();
        qbits = '0;
        for (int j = 0; j < 30; j++) begin
            tbits[2*j +: 2] = 2'(1 + ($unsigned($random(seed)) % 3));
        end
        send_alignment(16, qbits, 30, tbits, expv);
        check_eq("mismatch_score", expv, 0);

        // random groups queue up behind each other with fixed scoring
        left = NUM_RANDOM;
        while (left > 0) begin
            group = 1 + ($unsigned($random(seed)) % 6);
            if (group > left) begin
                group = left;
            end
            wait_drained();
            set_scores();
            repeat (group) begin
                run_random(1 + ($unsigned($random(seed)) % 16),
                           1 + ($unsigned($random(seed)) % 255));
            end
            left -= group;
        end

        wait_drained();
        // quiet period where the consumer catches any extra score
        repeat (40) @(negedge PicoClk);
        if (score_valid || exp_q.size() != 0) begin
            stop_on_error("extra score left after the last alignment");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule
